/* logic/exe_macros.svh */
`ifndef EXE_MACROS_SVH
`define EXE_MACROS_SVH

// Datapath and address width
`define XLEN 32

// Register file index width
`define REG_ADDR_W 5

// Data memory depth in words
`define DMEM_WORDS 256

`endif

/* logic/exePkg.sv */
`include "exe_macros.svh"

package exePkg;

	typedef enum logic [3:0] {
		aluAdd  = 4'd0,
		aluSub  = 4'd1,
		aluSll  = 4'd2,
		aluSlt  = 4'd3,
		aluSltu = 4'd4,
		aluXor  = 4'd5,
		aluSrl  = 4'd6,
		aluSra  = 4'd7,
		aluOr   = 4'd8,
		aluAnd  = 4'd9
	} aluFn;

	// Write-back source in stage 6
	typedef enum logic [2:0] {
		wbAlu    = 3'd0,
		wbLink   = 3'd1,
		wbMulDiv = 3'd2,
		wbUpper  = 3'd3,
		wbMem    = 3'd4,
		wbAuipc  = 3'd5
	} wbSel;

	typedef enum logic [3:0] {
		memNone = 4'd0,
		memLb   = 4'd1,
		memLh   = 4'd2,
		memLw   = 4'd3,
		memLbu  = 4'd4,
		memLhu  = 4'd5,
		memSb   = 4'd6,
		memSh   = 4'd7,
		memSw   = 4'd8
	} memOp;

	typedef enum logic [2:0] {
		mdMul    = 3'd0,
		mdMulh   = 3'd1,
		mdMulhsu = 3'd2,
		mdMulhu  = 3'd3,
		mdDiv    = 3'd4,
		mdDivu   = 3'd5,
		mdRem    = 3'd6,
		mdRemu   = 3'd7
	} mulDivOp;

	// Everything stage 5 needs from issue
	typedef struct packed {
		logic [`XLEN-1:0] opA;
		logic [`XLEN-1:0] opB;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] bImm;
		logic [`XLEN-1:0] jImm;
		logic [`XLEN-1:0] uImm;
		logic [`REG_ADDR_W-1:0] rd;
		logic we;
		wbSel wbSel;
		aluFn aluFn;
		mulDivOp mulDivOp;
		logic bneq;
		logic btype;
		logic j;
		logic jr;
	} stage5Bundle;

	typedef struct packed {
		logic [`XLEN-1:0] aluRes;
		logic [`XLEN-1:0] mulDivRes;
		logic [`XLEN-1:0] uImm;
		logic [`XLEN-1:0] auipcVal;
		logic [`XLEN-1:0] pc;
		logic [`REG_ADDR_W-1:0] rd;
		logic we;
		wbSel wbSel;
	} stage6Bundle;

endpackage

/* logic/pipeReg.sv */
module pipeReg #(
	parameter type payloadT = logic
) (
	input logic clk,
	input logic nrst,
	input payloadT d,
	output payloadT q
);

	// Whole payload clears to zero, so enums land on their first value
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			q <= '0;
		else
			q <= d;
	end

endmodule

/* logic/alu.sv */
`include "exe_macros.svh"

module alu (
	input exePkg::aluFn aluFn,
	input logic [`XLEN-1:0] operandA,
	input logic [`XLEN-1:0] operandB,
	input logic bneq,
	input logic btype,
	output logic [`XLEN-1:0] result,
	output logic bTaken
);

	localparam int ShW = $clog2(`XLEN);

	logic [ShW-1:0] shamt;
	logic ltSigned;
	logic ltUnsigned;

	assign shamt = operandB[ShW-1:0];
	assign ltSigned = $signed(operandA) < $signed(operandB);
	assign ltUnsigned = operandA < operandB;

	always_comb
	begin
		case (aluFn)
			exePkg::aluAdd:  result = operandA + operandB;
			exePkg::aluSub:  result = operandA - operandB;
			exePkg::aluSll:  result = operandA << shamt;
			exePkg::aluSlt:  result = {{(`XLEN-1){1'b0}}, ltSigned};
			exePkg::aluSltu: result = {{(`XLEN-1){1'b0}}, ltUnsigned};
			exePkg::aluXor:  result = operandA ^ operandB;
			exePkg::aluSrl:  result = operandA >> shamt;
			exePkg::aluSra:  result = $unsigned($signed(operandA) >>> shamt);
			exePkg::aluOr:   result = operandA | operandB;
			exePkg::aluAnd:  result = operandA & operandB;
			default:         result = '0;
		endcase
	end

	// beq/bge/bgeu want a zero result, bne/blt/bltu a nonzero one
	assign bTaken = btype && ((result == '0) != bneq);

endmodule

/* logic/branchUnit.sv */
`include "exe_macros.svh"

module branchUnit (
	input logic [`XLEN-1:0] pc,
	input logic [`XLEN-1:0] operandA,
	input logic [`XLEN-1:0] bImm,
	input logic [`XLEN-1:0] jImm,
	input logic [`XLEN-1:0] iImm,
	input logic bTaken,
	input logic j,
	input logic jr,
	output logic [`XLEN-1:0] target,
	output logic bjTaken
);

	logic [`XLEN-1:0] jrSum;

	assign jrSum = operandA + iImm;

	always_comb
	begin
		if (jr)
			target = {jrSum[`XLEN-1:1], 1'b0}; // jalr drops bit 0
		else if (j)
			target = pc + jImm;
		else
			target = pc + bImm;
	end

	assign bjTaken = bTaken | j | jr;

endmodule

/* logic/mulDiv.sv */
`include "exe_macros.svh"

module mulDiv (
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	input exePkg::mulDivOp mulDivOp,
	output logic [`XLEN-1:0] res
);

	logic aSigned;
	logic bSigned;
	logic [2*`XLEN-1:0] aExt;
	logic [2*`XLEN-1:0] bExt;
	logic [2*`XLEN-1:0] product;
	logic [`XLEN-1:0] absA;
	logic [`XLEN-1:0] absB;
	logic [`XLEN-1:0] qMag;
	logic [`XLEN-1:0] rMag;
	logic divByZero;

	// Low half of mul is the same for any signedness
	assign aSigned = mulDivOp != exePkg::mdMulhu;
	assign bSigned = mulDivOp inside {exePkg::mdMul, exePkg::mdMulh};
	assign aExt = {{`XLEN{aSigned & a[`XLEN-1]}}, a};
	assign bExt = {{`XLEN{bSigned & b[`XLEN-1]}}, b};
	assign product = aExt * bExt;

	// Signed divide on magnitudes; min / -1 wraps back to the dividend
	assign absA = a[`XLEN-1] ? -a : a;
	assign absB = b[`XLEN-1] ? -b : b;
	assign qMag = absA / absB;
	assign rMag = absA % absB;
	assign divByZero = b == '0;

	always_comb
	begin
		case (mulDivOp)
			exePkg::mdMul: res = product[`XLEN-1:0];
			exePkg::mdMulh, exePkg::mdMulhsu, exePkg::mdMulhu:
				res = product[2*`XLEN-1:`XLEN];
			exePkg::mdDiv:
				res = divByZero ? '1 : ((a[`XLEN-1] ^ b[`XLEN-1]) ? -qMag : qMag);
			exePkg::mdDivu: res = divByZero ? '1 : a / b;
			exePkg::mdRem:
				res = divByZero ? a : (a[`XLEN-1] ? -rMag : rMag); // Sign follows dividend
			exePkg::mdRemu: res = divByZero ? a : a % b;
			default: res = '0;
		endcase
	end

endmodule

/* logic/dmemIf.sv */
`include "exe_macros.svh"

interface dmemIf;

	logic [$clog2(`DMEM_WORDS)-1:0] wordAddr;
	logic [`XLEN-1:0] wdata;
	logic [`XLEN/8-1:0] byteEn; // One bit per byte lane
	logic wen;
	logic [`XLEN-1:0] rdata;

	modport master (
		output wordAddr, wdata, byteEn, wen,
		input rdata
	);

	modport slave (
		input wordAddr, wdata, byteEn, wen,
		output rdata
	);

endinterface

/* logic/memWrap.sv */
`include "exe_macros.svh"

module memWrap (
	input logic clk,
	input logic nrst,
	input exePkg::memOp memOp,
	input logic [`XLEN-1:0] opA,
	input logic [`XLEN-1:0] opB,
	input logic [`XLEN-1:0] sImm,
	dmemIf.master mem,
	output logic [`XLEN-1:0] memOut6,
	output logic addrMisaligned6
);

	localparam int AddrW = $clog2(`DMEM_WORDS);
	localparam int LaneW = `XLEN / 8;

	logic isStore;
	logic isHalf;
	logic isWord;
	logic misaligned;
	logic [`XLEN-1:0] addr;
	logic [`XLEN-1:0] storeData;
	logic [LaneW-1:0] laneMask;
	exePkg::memOp op5;
	exePkg::memOp op6;
	logic [1:0] offset5;
	logic [1:0] offset6;
	logic misaligned5;
	logic [`XLEN-1:0] shifted;

	assign isStore = memOp inside {exePkg::memSb, exePkg::memSh, exePkg::memSw};
	assign isHalf = memOp inside {exePkg::memLh, exePkg::memLhu, exePkg::memSh};
	assign isWord = memOp inside {exePkg::memLw, exePkg::memSw};

	// Loads carry the I-immediate on opB, stores carry the data there
	assign addr = opA + (isStore ? sImm : opB);
	assign misaligned = (isHalf && addr[0]) || (isWord && addr[1:0] != 2'b00);

	always_comb
	begin
		storeData = opB;
		case (memOp)
			exePkg::memSb:
			begin
				storeData = {LaneW{opB[7:0]}};
				laneMask = LaneW'(1) << addr[1:0];
			end
			exePkg::memSh:
			begin
				storeData = {(LaneW/2){opB[15:0]}};
				laneMask = LaneW'(3) << addr[1:0];
			end
			exePkg::memSw: laneMask = '1;
			default: laneMask = '0;
		endcase
	end

	// Request register, dataMem acts on it one edge later
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			mem.wordAddr <= '0;
			mem.wdata <= '0;
			mem.byteEn <= '0;
			mem.wen <= 1'b0;
			op5 <= exePkg::memNone;
			offset5 <= '0;
			misaligned5 <= 1'b0;
			op6 <= exePkg::memNone;
			offset6 <= '0;
			addrMisaligned6 <= 1'b0;
		end
		else
		begin
			mem.wordAddr <= addr[AddrW+1:2];
			mem.wdata <= storeData;
			mem.byteEn <= misaligned ? '0 : laneMask; // Misaligned store writes nothing
			mem.wen <= isStore;
			op5 <= memOp;
			offset5 <= addr[1:0];
			misaligned5 <= misaligned;
			op6 <= op5;
			offset6 <= offset5;
			addrMisaligned6 <= misaligned5;
		end
	end

	assign shifted = mem.rdata >> {offset6, 3'b000};

	always_comb
	begin
		if (addrMisaligned6)
			memOut6 = '0;
		else
		begin
			case (op6)
				exePkg::memLb:  memOut6 = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
				exePkg::memLbu: memOut6 = {{(`XLEN-8){1'b0}}, shifted[7:0]};
				exePkg::memLh:  memOut6 = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
				exePkg::memLhu: memOut6 = {{(`XLEN-16){1'b0}}, shifted[15:0]};
				exePkg::memLw:  memOut6 = mem.rdata;
				default:        memOut6 = '0;
			endcase
		end
	end

endmodule

/* logic/dataMem.sv */
`include "exe_macros.svh"

module dataMem (
	input logic clk,
	input logic nrst,
	dmemIf.slave mem
);

	logic [`XLEN-1:0] ram [`DMEM_WORDS];

	// Byte-lane writes
	always_ff @(posedge clk)
	begin
		if (mem.wen)
		begin
			for (int i = 0; i < `XLEN/8; i++)
			begin
				if (mem.byteEn[i])
					ram[mem.wordAddr][8*i +: 8] <= mem.wdata[8*i +: 8];
			end
		end
	end

	// Registered read, returns the word as it was before this edge
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			mem.rdata <= '0;
		else
			mem.rdata <= ram[mem.wordAddr];
	end

endmodule

/* logic/exeStage.sv */
`include "exe_macros.svh"

module exeStage (
	input logic clk,
	input logic nrst,
	input logic [`XLEN-1:0] opA,
	input logic [`XLEN-1:0] opB,
	input logic [`REG_ADDR_W-1:0] rd,
	input logic we,
	input exePkg::wbSel wbSel,
	input exePkg::aluFn aluFn,
	input logic [`XLEN-1:0] bImm,
	input logic [`XLEN-1:0] jImm,
	input logic [`XLEN-1:0] uImm,
	input logic [`XLEN-1:0] sImm,
	input logic bneq,
	input logic btype,
	input logic j,
	input logic jr,
	input exePkg::memOp memOp,
	input exePkg::mulDivOp mulDivOp,
	input logic [`XLEN-1:0] pc,
	output logic [`XLEN-1:0] target,
	output logic bjTaken,
	output logic [`XLEN-1:0] wbData6,
	output logic [`REG_ADDR_W-1:0] rd6,
	output logic we6,
	output logic addrMisaligned6
);

	exePkg::stage5Bundle s4;
	exePkg::stage5Bundle s5;
	exePkg::stage6Bundle s6In;
	exePkg::stage6Bundle s6;
	logic [`XLEN-1:0] aluRes5;
	logic [`XLEN-1:0] mulDivRes5;
	logic [`XLEN-1:0] memOut6;
	logic bTaken5;

	dmemIf dmemBus ();

	always_comb
	begin
		s4.opA = opA;
		s4.opB = opB;
		s4.pc = pc;
		s4.bImm = bImm;
		s4.jImm = jImm;
		s4.uImm = uImm;
		s4.rd = rd;
		s4.we = we;
		s4.wbSel = wbSel;
		s4.aluFn = aluFn;
		s4.mulDivOp = mulDivOp;
		s4.bneq = bneq;
		s4.btype = btype;
		s4.j = j;
		s4.jr = jr;
	end

	pipeReg #(.payloadT(exePkg::stage5Bundle)) stage5Reg (
		.clk  (clk),
		.nrst (nrst),
		.d    (s4),
		.q    (s5)
	);

	alu exeAlu (
		.aluFn    (s5.aluFn),
		.operandA (s5.opA),
		.operandB (s5.opB),
		.bneq     (s5.bneq),
		.btype    (s5.btype),
		.result   (aluRes5),
		.bTaken   (bTaken5)
	);

	branchUnit exeBu (
		.pc       (s5.pc),
		.operandA (s5.opA),
		.bImm     (s5.bImm),
		.jImm     (s5.jImm),
		.iImm     (s5.opB), // jalr offset rides on opB
		.bTaken   (bTaken5),
		.j        (s5.j),
		.jr       (s5.jr),
		.target   (target),
		.bjTaken  (bjTaken)
	);

	mulDiv exeMulDiv (
		.a        (s5.opA),
		.b        (s5.opB),
		.mulDivOp (s5.mulDivOp),
		.res      (mulDivRes5)
	);

	// Memory path takes stage 4 inputs and keeps its own pipeline
	memWrap dmemWrap (
		.clk             (clk),
		.nrst            (nrst),
		.memOp           (memOp),
		.opA             (opA),
		.opB             (opB),
		.sImm            (sImm),
		.mem             (dmemBus),
		.memOut6         (memOut6),
		.addrMisaligned6 (addrMisaligned6)
	);

	dataMem dmem (
		.clk  (clk),
		.nrst (nrst),
		.mem  (dmemBus)
	);

	always_comb
	begin
		s6In.aluRes = aluRes5;
		s6In.mulDivRes = mulDivRes5;
		s6In.uImm = s5.uImm;
		s6In.auipcVal = s5.pc + s5.uImm;
		s6In.pc = s5.pc;
		s6In.rd = s5.rd;
		s6In.we = s5.we;
		s6In.wbSel = s5.wbSel;
	end

	pipeReg #(.payloadT(exePkg::stage6Bundle)) stage6Reg (
		.clk  (clk),
		.nrst (nrst),
		.d    (s6In),
		.q    (s6)
	);

	assign rd6 = s6.rd;
	assign we6 = s6.we;

	// Write-back select
	always_comb
	begin
		case (s6.wbSel)
			exePkg::wbAlu:    wbData6 = s6.aluRes;
			exePkg::wbLink:   wbData6 = s6.pc + `XLEN'(4); // Return address
			exePkg::wbMulDiv: wbData6 = s6.mulDivRes;
			exePkg::wbUpper:  wbData6 = s6.uImm;
			exePkg::wbMem:    wbData6 = memOut6;
			exePkg::wbAuipc:  wbData6 = s6.auipcVal;
			default:          wbData6 = '0;
		endcase
	end

endmodule

/* verification/exeStageTb.sv */
`include "exe_macros.svh"

module exeStageTb;

	localparam int Period = 8;
	localparam int ResetCycles = 16;
	localparam int RandomRows = 64;
	localparam int FlushRows = 2;
	localparam int Margin = 20;
	localparam logic [`XLEN-1:0] TablePc = 32'h100;
	localparam logic [`XLEN-1:0] BrImm = 32'h20;
	localparam logic [`XLEN-1:0] JumpImm = 32'h40;

	// One issued instruction and what it should produce
	typedef struct packed {
		exePkg::wbSel ws;
		exePkg::aluFn fn;
		exePkg::mulDivOp md;
		exePkg::memOp mo;
		logic [3:0] ctl; // bneq, btype, j, jr
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		logic [`XLEN-1:0] imm; // Shared by bImm, uImm and sImm
		logic [`XLEN-1:0] pc;
		logic [`REG_ADDR_W-1:0] rd;
		logic we;
		logic [`XLEN-1:0] eTarget;
		logic eTaken;
		logic [`XLEN-1:0] eWb;
		logic eMis;
		logic chk;
	} rowT;

	logic clk = 1'b0;
	logic nrst;
	logic [`XLEN-1:0] opA;
	logic [`XLEN-1:0] opB;
	logic [`REG_ADDR_W-1:0] rd;
	logic we;
	exePkg::wbSel wbSel;
	exePkg::aluFn aluFn;
	logic [`XLEN-1:0] bImm;
	logic [`XLEN-1:0] jImm;
	logic [`XLEN-1:0] uImm;
	logic [`XLEN-1:0] sImm;
	logic bneq;
	logic btype;
	logic j;
	logic jr;
	exePkg::memOp memOp;
	exePkg::mulDivOp mulDivOp;
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] target;
	logic bjTaken;
	logic [`XLEN-1:0] wbData6;
	logic [`REG_ADDR_W-1:0] rd6;
	logic we6;
	logic addrMisaligned6;

	rowT rows[$];
	rowT q5[$]; // Waiting for the stage-5 check
	rowT q6[$];
	logic [15:0] lfsr = 16'd16481;
	logic tableReady = 1'b0;

	exeStage DUT (.*);

	always #(Period / 2) clk = ~clk;

	function automatic logic [31:0] randBits(int n);
		logic [31:0] v;
		logic bitOut;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			bitOut = lfsr[0];
			lfsr = lfsr >> 1;
			if (bitOut)
				lfsr = lfsr ^ 16'hB400; // x^16 + x^14 + x^13 + x^11 + 1
			v = {v[30:0], bitOut};
		end
		return v;
	endfunction

	function automatic logic [31:0] refAlu(exePkg::aluFn fn, logic [31:0] a, logic [31:0] b);
		logic [4:0] sh;
		logic [31:0] fill;
		sh = b[4:0];
		fill = a[31] ? ~(32'hFFFFFFFF >> sh) : 32'h0; // Sign bits shifted in by sra
		case (fn)
			exePkg::aluAdd:  return a + b;
			exePkg::aluSub:  return a - b;
			exePkg::aluSll:  return a << sh;
			exePkg::aluSlt:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
			exePkg::aluSltu: return {31'b0, a < b};
			exePkg::aluXor:  return a ^ b;
			exePkg::aluSrl:  return a >> sh;
			exePkg::aluSra:  return (a >> sh) | fill;
			exePkg::aluOr:   return a | b;
			exePkg::aluAnd:  return a & b;
			default:         return 32'h0;
		endcase
	endfunction

	function automatic logic [31:0] refMulDiv(exePkg::mulDivOp op, logic [31:0] a,
			logic [31:0] b);
		longint sa;
		longint sb;
		longint ub;
		logic ovf;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		ub = longint'({32'h0, b});
		ovf = (a == 32'h80000000) && (b == 32'hFFFFFFFF);
		case (op)
			exePkg::mdMul:    return 32'(sa * sb);
			exePkg::mdMulh:   return 32'((sa * sb) >>> 32);
			exePkg::mdMulhsu: return 32'((sa * ub) >>> 32);
			exePkg::mdMulhu:  return 32'(({32'h0, a} * {32'h0, b}) >> 32);
			exePkg::mdDiv:    return (b == 0) ? 32'hFFFFFFFF : (ovf ? a : 32'(sa / sb));
			exePkg::mdDivu:   return (b == 0) ? 32'hFFFFFFFF : a / b;
			exePkg::mdRem:    return (b == 0) ? a : (ovf ? 32'h0 : 32'(sa % sb));
			exePkg::mdRemu:   return (b == 0) ? a : a % b;
			default:          return 32'h0;
		endcase
	endfunction

	// All-zero row is an add with no memory access and nothing checked
	function automatic rowT idleRow();
		rowT r;
		r = '0;
		return r;
	endfunction

	function automatic rowT randomRow(int i);
		rowT r;
		logic [1:0] sel;
		r = idleRow();
		r.chk = 1'b1;
		r.pc = randBits(30) << 2;
		r.imm = randBits(32);
		r.a = randBits(32);
		r.b = randBits(32);
		r.rd = 5'(i);
		r.we = 1'(i % 2);
		if (i % 2 == 0)
		begin
			r.ws = exePkg::wbMulDiv;
			r.md = exePkg::mulDivOp'(3'(randBits(3)));
			sel = 2'(randBits(2));
			if (sel == 2'd0)
				r.b = '0; // Divide by zero
			else if (sel == 2'd1)
			begin
				r.a = 32'h80000000;
				r.b = 32'hFFFFFFFF;
			end
			r.eWb = refMulDiv(r.md, r.a, r.b);
		end
		else
		begin
			r.fn = exePkg::aluFn'(4'(randBits(4) % 10));
			r.ctl = {2'(randBits(2)), 2'b00};
			r.eWb = refAlu(r.fn, r.a, r.b);
			r.eTaken = r.ctl[2] && ((r.eWb == 0) != r.ctl[3]);
		end
		r.eTarget = r.pc + r.imm;
		return r;
	endfunction

	task automatic put(exePkg::wbSel ws, exePkg::aluFn fn, exePkg::mulDivOp md,
			exePkg::memOp mo, logic [3:0] ctl, logic [31:0] a, logic [31:0] b,
			logic [31:0] imm, logic [31:0] eTarget, logic eTaken, logic [31:0] eWb, logic eMis);
		rowT r;
		r = idleRow();
		r.ws = ws;
		r.fn = fn;
		r.md = md;
		r.mo = mo;
		r.ctl = ctl;
		r.a = a;
		r.b = b;
		r.imm = imm;
		r.pc = TablePc;
		r.rd = 5'(rows.size());
		r.we = 1'(rows.size() % 2);
		r.eTarget = eTarget;
		r.eTaken = eTaken;
		r.eWb = eWb;
		r.eMis = eMis;
		r.chk = 1'b1;
		rows.push_back(r);
	endtask

	task automatic aluRow(exePkg::aluFn fn, logic [3:0] ctl, logic [31:0] a, logic [31:0] b,
			logic eTaken, logic [31:0] eWb);
		put(exePkg::wbAlu, fn, exePkg::mdMul, exePkg::memNone, ctl, a, b, BrImm,
			TablePc + BrImm, eTaken, eWb, 1'b0);
	endtask

	task automatic mdRow(exePkg::mulDivOp md, logic [31:0] a, logic [31:0] b,
			logic [31:0] eWb);
		put(exePkg::wbMulDiv, exePkg::aluAdd, md, exePkg::memNone, 4'b0000, a, b, BrImm,
			TablePc + BrImm, 1'b0, eWb, 1'b0);
	endtask

	// Stores write back the ALU sum of opA and opB, loads the memory data
	task automatic memRow(exePkg::memOp mo, logic [31:0] a, logic [31:0] b, logic [31:0] imm,
			logic [31:0] eWb, logic eMis);
		exePkg::wbSel ws;
		ws = (mo inside {exePkg::memSb, exePkg::memSh, exePkg::memSw}) ? exePkg::wbAlu
			: exePkg::wbMem;
		put(ws, exePkg::aluAdd, exePkg::mdMul, mo, 4'b0000, a, b, imm, TablePc + imm, 1'b0,
			eWb, eMis);
	endtask

	task automatic buildTable();
		aluRow(exePkg::aluAdd, 4'b0000, 32'd5, 32'd7, 1'b0, 32'd12);
		aluRow(exePkg::aluSub, 4'b0000, 32'd5, 32'd7, 1'b0, 32'hFFFFFFFE);
		aluRow(exePkg::aluSll, 4'b0000, 32'h3, 32'h24, 1'b0, 32'h30); // Only 5 shift bits count
		aluRow(exePkg::aluSlt, 4'b0000, 32'hFFFFFFFF, 32'h1, 1'b0, 32'h1);
		aluRow(exePkg::aluSltu, 4'b0000, 32'hFFFFFFFF, 32'h1, 1'b0, 32'h0);
		aluRow(exePkg::aluXor, 4'b0000, 32'hF0F0F0F0, 32'h0FF00FF0, 1'b0, 32'hFF00FF00);
		aluRow(exePkg::aluSrl, 4'b0000, 32'h80000000, 32'h4, 1'b0, 32'h08000000);
		aluRow(exePkg::aluSra, 4'b0000, 32'h80000000, 32'h4, 1'b0, 32'hF8000000);
		aluRow(exePkg::aluOr, 4'b0000, 32'h00F0, 32'h0F00, 1'b0, 32'h0FF0);
		aluRow(exePkg::aluAnd, 4'b0000, 32'hFF00FF00, 32'h0F0F0F0F, 1'b0, 32'h0F000F00);
		// beq, bne twice, blt, bge, bltu, bgeu
		aluRow(exePkg::aluSub, 4'b0100, 32'd9, 32'd9, 1'b1, 32'h0);
		aluRow(exePkg::aluSub, 4'b1100, 32'd9, 32'd9, 1'b0, 32'h0);
		aluRow(exePkg::aluSub, 4'b1100, 32'd9, 32'd4, 1'b1, 32'h5);
		aluRow(exePkg::aluSlt, 4'b1100, 32'hFFFFFFFE, 32'd3, 1'b1, 32'h1);
		aluRow(exePkg::aluSlt, 4'b0100, 32'hFFFFFFFE, 32'd3, 1'b0, 32'h1);
		aluRow(exePkg::aluSltu, 4'b1100, 32'hFFFFFFFE, 32'd3, 1'b0, 32'h0);
		aluRow(exePkg::aluSltu, 4'b0100, 32'hFFFFFFFE, 32'd3, 1'b1, 32'h0);
		// jal, jalr, then both flags where jalr wins
		put(exePkg::wbLink, exePkg::aluAdd, exePkg::mdMul, exePkg::memNone, 4'b0010,
			32'h0, 32'h0, BrImm, TablePc + JumpImm, 1'b1, TablePc + 4, 1'b0);
		put(exePkg::wbLink, exePkg::aluAdd, exePkg::mdMul, exePkg::memNone, 4'b0001,
			32'h2001, 32'h10, BrImm, 32'h2010, 1'b1, TablePc + 4, 1'b0);
		put(exePkg::wbLink, exePkg::aluAdd, exePkg::mdMul, exePkg::memNone, 4'b0011,
			32'h3000, 32'h5, BrImm, 32'h3004, 1'b1, TablePc + 4, 1'b0);
		put(exePkg::wbUpper, exePkg::aluAdd, exePkg::mdMul, exePkg::memNone, 4'b0000,
			32'h0, 32'h0, 32'h12345000, 32'h12345100, 1'b0, 32'h12345000, 1'b0);
		put(exePkg::wbAuipc, exePkg::aluAdd, exePkg::mdMul, exePkg::memNone, 4'b0000,
			32'h0, 32'h0, 32'hFFFFF000, 32'hFFFFF100, 1'b0, 32'hFFFFF100, 1'b0);
		mdRow(exePkg::mdMul, 32'd7, 32'hFFFFFFFD, 32'hFFFFFFEB);
		mdRow(exePkg::mdMulh, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'h0);
		mdRow(exePkg::mdMulhsu, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'hFFFFFFFF);
		mdRow(exePkg::mdMulhu, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'hFFFFFFFE);
		mdRow(exePkg::mdDiv, 32'hFFFFFFF9, 32'd2, 32'hFFFFFFFD);
		mdRow(exePkg::mdRem, 32'hFFFFFFF9, 32'd2, 32'hFFFFFFFF);
		mdRow(exePkg::mdDiv, 32'h1234, 32'h0, 32'hFFFFFFFF);
		mdRow(exePkg::mdRem, 32'h1234, 32'h0, 32'h1234);
		mdRow(exePkg::mdDivu, 32'h1234, 32'h0, 32'hFFFFFFFF);
		mdRow(exePkg::mdDiv, 32'h80000000, 32'hFFFFFFFF, 32'h80000000);
		mdRow(exePkg::mdRem, 32'h80000000, 32'hFFFFFFFF, 32'h0);
		// Word at 0x40, each load right after a store sees the new data
		memRow(exePkg::memSw, 32'h40, 32'hA1B2C3D4, 32'h0, 32'hA1B2C414, 1'b0);
		memRow(exePkg::memLw, 32'h40, 32'h0, 32'h0, 32'hA1B2C3D4, 1'b0);
		memRow(exePkg::memLb, 32'h40, 32'h1, 32'h0, 32'hFFFFFFC3, 1'b0);
		memRow(exePkg::memLbu, 32'h40, 32'h3, 32'h0, 32'h000000A1, 1'b0);
		memRow(exePkg::memLh, 32'h40, 32'h2, 32'h0, 32'hFFFFA1B2, 1'b0);
		memRow(exePkg::memLhu, 32'h40, 32'h0, 32'h0, 32'h0000C3D4, 1'b0);
		memRow(exePkg::memSb, 32'h40, 32'h5E, 32'h2, 32'h9E, 1'b0);
		memRow(exePkg::memLb, 32'h40, 32'h2, 32'h0, 32'h0000005E, 1'b0);
		memRow(exePkg::memSh, 32'h40, 32'h7788, 32'h0, 32'h77C8, 1'b0);
		memRow(exePkg::memLw, 32'h40, 32'h0, 32'h0, 32'hA15E7788, 1'b0);
		memRow(exePkg::memSw, 32'h40, 32'hDEADBEEF, 32'h2, 32'hDEADBF2F, 1'b1);
		memRow(exePkg::memSh, 32'h40, 32'h1111, 32'h1, 32'h1151, 1'b1);
		memRow(exePkg::memLh, 32'h40, 32'h3, 32'h0, 32'h0, 1'b1);
		memRow(exePkg::memLw, 32'h40, 32'h1, 32'h0, 32'h0, 1'b1);
		memRow(exePkg::memLw, 32'h40, 32'h0, 32'h0, 32'hA15E7788, 1'b0); // Unchanged
	endtask

	task automatic check(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("tests failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic drive(rowT r);
		opA = r.a;
		opB = r.b;
		rd = r.rd;
		we = r.we;
		wbSel = r.ws;
		aluFn = r.fn;
		bImm = r.imm;
		jImm = JumpImm;
		uImm = r.imm;
		sImm = r.imm;
		{bneq, btype, j, jr} = r.ctl;
		memOp = r.mo;
		mulDivOp = r.md;
		pc = r.pc;
	endtask

	// One cycle: check older rows, then issue the next one
	task automatic step(rowT r);
		rowT e;
		@(negedge clk);
		if (q5.size() > 0)
		begin
			e = q5.pop_front();
			if (e.chk)
			begin
				check("target", target, e.eTarget);
				check("bjTaken", 32'(bjTaken), 32'(e.eTaken));
			end
		end
		if (q6.size() == 2)
		begin
			e = q6.pop_front();
			if (e.chk)
			begin
				check("wbData6", wbData6, e.eWb);
				check("rd6", 32'(rd6), 32'(e.rd));
				check("we6", 32'(we6), 32'(e.we));
				check("addrMisaligned6", 32'(addrMisaligned6), 32'(e.eMis));
			end
		end
		drive(r);
		q5.push_back(r);
		q6.push_back(r);
	endtask

	initial
	begin
		int limit;
		wait (tableReady);
		limit = rows.size() + RandomRows + ResetCycles + FlushRows + Margin;
		#(limit * Period);
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("tests failed");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		nrst = 1'b0;
		drive(idleRow());
		buildTable();
		tableReady = 1'b1;
		repeat (ResetCycles) @(negedge clk);
		nrst = 1'b1;
		foreach (rows[k])
			step(rows[k]);
		for (int i = 0; i < RandomRows; i++)
			step(randomRow(i));
		repeat (FlushRows) step(idleRow()); // Drain both stages
		$display("all tests passed");
		$finish;
	end

endmodule

/* compile.f */
+incdir+logic
logic/exePkg.sv
logic/pipeReg.sv
logic/alu.sv
logic/branchUnit.sv
logic/mulDiv.sv
logic/dmemIf.sv
logic/memWrap.sv
logic/dataMem.sv
logic/exeStage.sv
verification/exeStageTb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the exeStage testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -f compile.f --top-module exeStageTb -o exeSim
	@out=$$(./obj_dir/exeSim 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
